// File: exe_pkg.sv
package exe_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int imm_width      = 16;
    localparam int exccode_width  = 5;

    // cause codes seen by cp0
    localparam logic [exccode_width-1:0] exc_adel = 5'd4;
    localparam logic [exccode_width-1:0] exc_ades = 5'd5;
    localparam logic [exccode_width-1:0] exc_ov   = 5'd12;

    // data cache address split
    localparam int tag_width    = 20;
    localparam int index_width  = 8;
    localparam int offset_width = 4;

    // shift amount field inside the immediate
    localparam int sa_lsb   = 6;
    localparam int sa_width = 5;

    typedef enum logic [3:0] {
        alu_add, alu_addu, alu_sub, alu_subu,
        alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rs, src1_sa, src1_pc
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rt, src2_imm_sext, src2_imm_zext, src2_eight
    } src2_sel_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw,
        mem_sb, mem_sh, mem_sw
    } mem_kind_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } cache_size_e;

    function automatic logic is_load(mem_kind_e kind);
        return kind inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw};
    endfunction

    function automatic logic is_store(mem_kind_e kind);
        return kind inside {mem_sb, mem_sh, mem_sw};
    endfunction

    function automatic cache_size_e access_size(mem_kind_e kind);
        if (kind inside {mem_lb, mem_lbu, mem_sb}) return size_byte;
        if (kind inside {mem_lh, mem_lhu, mem_sh}) return size_half;
        return size_word;
    endfunction

endpackage

// File: exe_operand_select.sv
`timescale 1ns/1ps

module exe_operand_select (
    input  exe_pkg::src1_sel_e                 src1_sel,
    input  exe_pkg::src2_sel_e                 src2_sel,
    input  logic [exe_pkg::imm_width-1:0]      imm,
    input  logic [exe_pkg::data_width-1:0]     pc,
    input  logic [exe_pkg::data_width-1:0]     rs_value,
    input  logic [exe_pkg::data_width-1:0]     rt_value,
    output logic [exe_pkg::data_width-1:0]     alu_src1,
    output logic [exe_pkg::data_width-1:0]     alu_src2,
    output logic [exe_pkg::data_width-1:0]     mem_addr
);

    localparam int ext_width = exe_pkg::data_width - exe_pkg::imm_width;
    localparam int sa_pad    = exe_pkg::data_width - exe_pkg::sa_width;

    logic [exe_pkg::data_width-1:0] imm_sext;
    logic [exe_pkg::data_width-1:0] imm_zext;
    logic [exe_pkg::data_width-1:0] shamt;

    assign imm_sext = {{ext_width{imm[exe_pkg::imm_width-1]}}, imm};
    assign imm_zext = {{ext_width{1'b0}}, imm};

    // sa lives in instruction bits 10:6
    assign shamt = {{sa_pad{1'b0}}, imm[exe_pkg::sa_lsb +: exe_pkg::sa_width]};

    always_comb begin
        case (src1_sel)
            exe_pkg::src1_sa: begin
                alu_src1 = shamt;
            end
            exe_pkg::src1_pc: begin
                alu_src1 = pc;
            end
            default: begin
                alu_src1 = rs_value;
            end
        endcase
    end

    always_comb begin
        case (src2_sel)
            exe_pkg::src2_imm_sext: begin
                alu_src2 = imm_sext;
            end
            exe_pkg::src2_imm_zext: begin
                alu_src2 = imm_zext;
            end
            // link address for jal/bal is pc + 8
            exe_pkg::src2_eight: begin
                alu_src2 = exe_pkg::data_width'(8);
            end
            default: begin
                alu_src2 = rt_value;
            end
        endcase
    end

    // load/store effective address, independent of the alu
    assign mem_addr = rs_value + imm_sext;

endmodule

// File: exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
    input  exe_pkg::alu_op_e                   alu_op,
    input  logic [exe_pkg::data_width-1:0]     src1,
    input  logic [exe_pkg::data_width-1:0]     src2,
    output logic [exe_pkg::data_width-1:0]     result,
    output logic                               overflow
);

    localparam int msb       = exe_pkg::data_width - 1;
    localparam int half      = exe_pkg::data_width / 2;
    localparam int shw       = $clog2(exe_pkg::data_width);

    logic [msb:0] sum;
    logic [msb:0] diff;
    logic [shw-1:0] shamt;
    logic         add_ov;
    logic         sub_ov;
    logic         lt_signed;
    logic         lt_unsigned;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // same-sign operands, result sign flipped
    assign add_ov = (src1[msb] == src2[msb]) && (sum[msb] != src1[msb]);
    // opposite signs, result takes the sign of src2
    assign sub_ov = (src1[msb] != src2[msb]) && (diff[msb] != src1[msb]);

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    assign shamt = src1[shw-1:0];

    always_comb begin
        case (alu_op)
            exe_pkg::alu_add, exe_pkg::alu_addu: begin
                result = sum;
            end
            exe_pkg::alu_sub, exe_pkg::alu_subu: begin
                result = diff;
            end
            exe_pkg::alu_slt: begin
                result = {{msb{1'b0}}, lt_signed};
            end
            exe_pkg::alu_sltu: begin
                result = {{msb{1'b0}}, lt_unsigned};
            end
            exe_pkg::alu_and: begin
                result = src1 & src2;
            end
            exe_pkg::alu_or: begin
                result = src1 | src2;
            end
            exe_pkg::alu_xor: begin
                result = src1 ^ src2;
            end
            exe_pkg::alu_nor: begin
                result = ~(src1 | src2);
            end
            exe_pkg::alu_sll: begin
                result = src2 << shamt;
            end
            exe_pkg::alu_srl: begin
                result = src2 >> shamt;
            end
            exe_pkg::alu_sra: begin
                result = $signed(src2) >>> shamt;
            end
            exe_pkg::alu_lui: begin
                result = {src2[half-1:0], {half{1'b0}}};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // only the trapping forms report overflow
    always_comb begin
        case (alu_op)
            exe_pkg::alu_add: overflow = add_ov;
            exe_pkg::alu_sub: overflow = sub_ov;
            default:          overflow = 1'b0;
        endcase
    end

endmodule

// File: exe_mem_request.sv
`timescale 1ns/1ps

module exe_mem_request (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  item_valid,
    input  logic                                  clear_all,
    input  logic                                  pms_allowin,
    input  exe_pkg::mem_kind_e                    mem_kind,
    input  logic [exe_pkg::data_width-1:0]        mem_addr,
    input  logic [exe_pkg::data_width-1:0]        rt_value,
    input  logic                                  detect_overflow,
    input  logic                                  alu_overflow,
    input  logic                                  ds_except,
    input  logic [exe_pkg::exccode_width-1:0]     ds_exccode,
    input  logic [exe_pkg::data_width-1:0]        pc,
    input  logic                                  cache_addr_ok,
    output logic                                  mem_ready,
    output logic                                  except,
    output logic [exe_pkg::exccode_width-1:0]     exccode,
    output logic [exe_pkg::data_width-1:0]        badvaddr,
    output logic                                  cache_valid,
    output logic                                  cache_op,
    output logic [exe_pkg::tag_width-1:0]         cache_tag,
    output logic [exe_pkg::index_width-1:0]       cache_index,
    output logic [exe_pkg::offset_width-1:0]      cache_offset,
    output exe_pkg::cache_size_e                  cache_size,
    output logic [exe_pkg::data_width/8-1:0]      cache_wstrb,
    output logic [exe_pkg::data_width-1:0]        cache_wdata
);

    localparam int dw = exe_pkg::data_width;

    logic          is_ld;
    logic          is_st;
    logic          is_mem;
    logic          misaligned;
    logic          ov;
    logic          adel;
    logic          ades;
    logic          accepted;
    logic [dw-1:0] phys_addr;

    assign is_ld  = exe_pkg::is_load(mem_kind);
    assign is_st  = exe_pkg::is_store(mem_kind);
    assign is_mem = is_ld || is_st;

    always_comb begin
        case (mem_kind)
            exe_pkg::mem_lh, exe_pkg::mem_lhu, exe_pkg::mem_sh: misaligned = mem_addr[0];
            exe_pkg::mem_lw, exe_pkg::mem_sw:                   misaligned = |mem_addr[1:0];
            default:                                            misaligned = 1'b0;
        endcase
    end

    assign ov   = detect_overflow && alu_overflow;
    assign adel = is_ld && misaligned;
    assign ades = is_st && misaligned;

    assign except = ds_except || ov || adel || ades;

    // earliest cause wins
    always_comb begin
        if (ds_except) begin
            exccode = ds_exccode;
        end else if (ov) begin
            exccode = exe_pkg::exc_ov;
        end else if (adel) begin
            exccode = exe_pkg::exc_adel;
        end else if (ades) begin
            exccode = exe_pkg::exc_ades;
        end else begin
            exccode = '0;
        end
    end

    assign badvaddr = ds_except ? pc : mem_addr;

    // store lane placement
    always_comb begin
        cache_wstrb = '0;
        cache_wdata = '0;
        case (mem_kind)
            exe_pkg::mem_sb: begin
                cache_wstrb = 4'b0001 << mem_addr[1:0];
                cache_wdata = {4{rt_value[7:0]}};
            end
            exe_pkg::mem_sh: begin
                cache_wstrb = mem_addr[1] ? 4'b1100 : 4'b0011;
                cache_wdata = {2{rt_value[15:0]}};
            end
            exe_pkg::mem_sw: begin
                cache_wstrb = 4'b1111;
                cache_wdata = rt_value;
            end
            default: begin
                cache_wstrb = '0;
                cache_wdata = '0;
            end
        endcase
    end

    // kseg0/kseg1 fold onto the low 512M
    assign phys_addr = {3'b000, mem_addr[dw-4:0]};

    assign cache_tag    = phys_addr[dw-1 -: exe_pkg::tag_width];
    assign cache_index  = phys_addr[exe_pkg::offset_width +: exe_pkg::index_width];
    assign cache_offset = phys_addr[exe_pkg::offset_width-1:0];
    assign cache_size   = exe_pkg::access_size(mem_kind);
    assign cache_op     = is_st;

    // the item leaves in the same cycle the cache takes it
    assign cache_valid = item_valid && is_mem && !except && pms_allowin && !clear_all;

    assign accepted  = cache_valid && cache_addr_ok;
    assign mem_ready = !is_mem || except || accepted;

    // a pending request keeps its item and address until the cache takes it
    a_request_held: assert property (
        @(posedge clk) disable iff (reset)
        item_valid && is_mem && !mem_ready && !clear_all
            |=> item_valid && $stable(mem_addr) && $stable(mem_kind)
    );

endmodule

// File: exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clear_all,
    input  logic                                  ds_valid,
    input  exe_pkg::alu_op_e                      ds_alu_op,
    input  exe_pkg::src1_sel_e                    ds_src1_sel,
    input  exe_pkg::src2_sel_e                    ds_src2_sel,
    input  logic [exe_pkg::imm_width-1:0]         ds_imm,
    input  logic [exe_pkg::data_width-1:0]        ds_pc,
    input  logic [exe_pkg::data_width-1:0]        ds_rs_value,
    input  logic [exe_pkg::data_width-1:0]        ds_rt_value,
    input  exe_pkg::mem_kind_e                    ds_mem_kind,
    input  logic                                  ds_detect_overflow,
    input  logic                                  ds_gr_we,
    input  logic [exe_pkg::reg_addr_width-1:0]    ds_dest,
    input  logic                                  ds_except,
    input  logic [exe_pkg::exccode_width-1:0]     ds_exccode,
    input  logic                                  pms_allowin,
    input  logic                                  cache_addr_ok,
    output logic                                  allowin,
    output logic                                  out_valid,
    output logic [exe_pkg::data_width-1:0]        out_result,
    output logic [exe_pkg::data_width-1:0]        out_mem_addr,
    output logic                                  out_gr_we,
    output logic [exe_pkg::reg_addr_width-1:0]    out_dest,
    output exe_pkg::mem_kind_e                    out_mem_kind,
    output logic                                  out_except,
    output logic [exe_pkg::exccode_width-1:0]     out_exccode,
    output logic [exe_pkg::data_width-1:0]        out_badvaddr,
    output logic                                  cache_valid,
    output logic                                  cache_op,
    output logic [exe_pkg::tag_width-1:0]         cache_tag,
    output logic [exe_pkg::index_width-1:0]       cache_index,
    output logic [exe_pkg::offset_width-1:0]      cache_offset,
    output exe_pkg::cache_size_e                  cache_size,
    output logic [exe_pkg::data_width/8-1:0]      cache_wstrb,
    output logic [exe_pkg::data_width-1:0]        cache_wdata
);

    localparam int dw = exe_pkg::data_width;

    logic es_valid;
    logic ready_go;
    logic mem_ready;

    // held instruction
    exe_pkg::alu_op_e                     alu_op_q;
    exe_pkg::src1_sel_e                   src1_sel_q;
    exe_pkg::src2_sel_e                   src2_sel_q;
    logic [exe_pkg::imm_width-1:0]        imm_q;
    logic [dw-1:0]                        pc_q;
    logic [dw-1:0]                        rs_q;
    logic [dw-1:0]                        rt_q;
    exe_pkg::mem_kind_e                   mem_kind_q;
    logic                                 detect_overflow_q;
    logic                                 gr_we_q;
    logic [exe_pkg::reg_addr_width-1:0]   dest_q;
    logic                                 ds_except_q;
    logic [exe_pkg::exccode_width-1:0]    ds_exccode_q;

    logic [dw-1:0] alu_src1;
    logic [dw-1:0] alu_src2;
    logic [dw-1:0] mem_addr;
    logic          alu_overflow;

    // a flush lets the stage drain without waiting on the cache
    assign ready_go  = mem_ready || clear_all;
    assign allowin   = !es_valid || (ready_go && pms_allowin);
    assign out_valid = es_valid && mem_ready && !clear_all;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (clear_all) begin
            es_valid <= 1'b0;
        end else if (allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && allowin) begin
            alu_op_q          <= ds_alu_op;
            src1_sel_q        <= ds_src1_sel;
            src2_sel_q        <= ds_src2_sel;
            imm_q             <= ds_imm;
            pc_q              <= ds_pc;
            rs_q              <= ds_rs_value;
            rt_q              <= ds_rt_value;
            mem_kind_q        <= ds_mem_kind;
            detect_overflow_q <= ds_detect_overflow;
            gr_we_q           <= ds_gr_we;
            dest_q            <= ds_dest;
            ds_except_q       <= ds_except;
            ds_exccode_q      <= ds_exccode;
        end
    end

    exe_operand_select u_operand_select (
        .src1_sel (src1_sel_q),
        .src2_sel (src2_sel_q),
        .imm      (imm_q),
        .pc       (pc_q),
        .rs_value (rs_q),
        .rt_value (rt_q),
        .alu_src1 (alu_src1),
        .alu_src2 (alu_src2),
        .mem_addr (mem_addr)
    );

    exe_alu u_alu (
        .alu_op   (alu_op_q),
        .src1     (alu_src1),
        .src2     (alu_src2),
        .result   (out_result),
        .overflow (alu_overflow)
    );

    exe_mem_request u_mem_request (
        .clk             (clk),
        .reset           (reset),
        .item_valid      (es_valid),
        .clear_all       (clear_all),
        .pms_allowin     (pms_allowin),
        .mem_kind        (mem_kind_q),
        .mem_addr        (mem_addr),
        .rt_value        (rt_q),
        .detect_overflow (detect_overflow_q),
        .alu_overflow    (alu_overflow),
        .ds_except       (ds_except_q),
        .ds_exccode      (ds_exccode_q),
        .pc              (pc_q),
        .cache_addr_ok   (cache_addr_ok),
        .mem_ready       (mem_ready),
        .except          (out_except),
        .exccode         (out_exccode),
        .badvaddr        (out_badvaddr),
        .cache_valid     (cache_valid),
        .cache_op        (cache_op),
        .cache_tag       (cache_tag),
        .cache_index     (cache_index),
        .cache_offset    (cache_offset),
        .cache_size      (cache_size),
        .cache_wstrb     (cache_wstrb),
        .cache_wdata     (cache_wdata)
    );

    assign out_mem_addr = mem_addr;
    assign out_gr_we    = gr_we_q;
    assign out_dest     = dest_q;
    assign out_mem_kind = mem_kind_q;

    // stage comes out of reset empty
    a_empty_after_reset: assert property (
        @(posedge clk) reset |=> !out_valid
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam time half_period = 20ns;
    localparam int  reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

// File: exe_stage_tb.sv
`timescale 1ns/1ps

module exe_stage_tb;

    localparam int n_items = 698;

    logic clk, reset, clear_all, ds_valid, pms_allowin, cache_addr_ok;
    exe_pkg::alu_op_e ds_alu_op;
    exe_pkg::src1_sel_e ds_src1_sel;
    exe_pkg::src2_sel_e ds_src2_sel;
    exe_pkg::mem_kind_e ds_mem_kind, out_mem_kind;
    exe_pkg::cache_size_e cache_size;
    logic [15:0] ds_imm;
    logic [31:0] ds_pc, ds_rs_value, ds_rt_value, out_result, out_mem_addr, out_badvaddr;
    logic [31:0] cache_wdata;
    logic ds_detect_overflow, ds_gr_we, ds_except, allowin, out_valid, out_gr_we, out_except;
    logic [4:0] ds_dest, ds_exccode, out_dest, out_exccode;
    logic cache_valid, cache_op;
    logic [19:0] cache_tag;
    logic [7:0] cache_index;
    logic [3:0] cache_offset, cache_wstrb;

    // stimulus per item id
    exe_pkg::alu_op_e a_op[n_items];
    exe_pkg::src1_sel_e a_s1[n_items];
    exe_pkg::src2_sel_e a_s2[n_items];
    exe_pkg::mem_kind_e a_kind[n_items];
    logic [15:0] a_imm[n_items];
    logic [31:0] a_pc[n_items], a_rs[n_items], a_rt[n_items];
    logic a_det[n_items], a_exc[n_items], a_we[n_items];
    logic [4:0] a_code[n_items], a_dest[n_items];

    int exp_q[$];
    int cur_id, next_id, wait_cnt, req_count, errors, test_errors, test_items;
    logic hold_back;
    string test_name;

    tb_clock_gen clock_i (.clk(clk), .reset(reset));

    exe_stage dut_i (.*);

    function automatic void exe_model(input int id, output logic [31:0] res,
            output logic [31:0] addr, output logic exc, output logic [4:0] code,
            output logic [31:0] badv, output exe_pkg::cache_size_e size,
            output logic [3:0] strb, output logic [31:0] wdata, output logic req);
        logic [31:0] a, b, sext;
        logic [32:0] wide;
        logic ov, mis, ld, st;
        exe_pkg::mem_kind_e k;
        k = a_kind[id];
        sext = {{16{a_imm[id][15]}}, a_imm[id]};
        a = (a_s1[id] == exe_pkg::src1_sa) ? {27'd0, a_imm[id][10:6]} :
            (a_s1[id] == exe_pkg::src1_pc) ? a_pc[id] : a_rs[id];
        case (a_s2[id])
            exe_pkg::src2_imm_sext: b = sext;
            exe_pkg::src2_imm_zext: b = {16'd0, a_imm[id]};
            exe_pkg::src2_eight: b = 32'd8;
            default: b = a_rt[id];
        endcase
        ov = 1'b0;
        case (a_op[id])
            exe_pkg::alu_add, exe_pkg::alu_addu: begin
                res = a + b;
                wide = {a[31], a} + {b[31], b};
                ov = (a_op[id] == exe_pkg::alu_add) && (wide[32] != wide[31]);
            end
            exe_pkg::alu_sub, exe_pkg::alu_subu: begin
                res = a - b;
                wide = {a[31], a} - {b[31], b};
                ov = (a_op[id] == exe_pkg::alu_sub) && (wide[32] != wide[31]);
            end
            exe_pkg::alu_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::alu_sltu: res = (a < b) ? 32'd1 : 32'd0;
            exe_pkg::alu_and: res = a & b;
            exe_pkg::alu_or: res = a | b;
            exe_pkg::alu_xor: res = a ^ b;
            exe_pkg::alu_nor: res = ~(a | b);
            exe_pkg::alu_sll: res = b << a[4:0];
            exe_pkg::alu_srl: res = b >> a[4:0];
            exe_pkg::alu_sra: res = $signed(b) >>> a[4:0];
            default: res = {b[15:0], 16'd0};
        endcase
        ov = ov && a_det[id];
        addr = a_rs[id] + sext;
        ld = k inside {exe_pkg::mem_lb, exe_pkg::mem_lbu, exe_pkg::mem_lh,
                       exe_pkg::mem_lhu, exe_pkg::mem_lw};
        st = k inside {exe_pkg::mem_sb, exe_pkg::mem_sh, exe_pkg::mem_sw};
        mis = (k inside {exe_pkg::mem_lh, exe_pkg::mem_lhu, exe_pkg::mem_sh}) ? addr[0] :
              (k inside {exe_pkg::mem_lw, exe_pkg::mem_sw}) ? (addr[1:0] != 2'd0) : 1'b0;
        exc = a_exc[id] || ov || mis;
        code = a_exc[id] ? a_code[id] : ov ? 5'd12 : (mis && ld) ? 5'd4 : mis ? 5'd5 : 5'd0;
        badv = a_exc[id] ? a_pc[id] : addr;
        size = (k inside {exe_pkg::mem_lb, exe_pkg::mem_lbu, exe_pkg::mem_sb}) ?
               exe_pkg::size_byte :
               (k inside {exe_pkg::mem_lh, exe_pkg::mem_lhu, exe_pkg::mem_sh}) ?
               exe_pkg::size_half : exe_pkg::size_word;
        strb = (k == exe_pkg::mem_sb) ? (4'b0001 << addr[1:0]) :
               (k == exe_pkg::mem_sh) ? (addr[1] ? 4'b1100 : 4'b0011) :
               (k == exe_pkg::mem_sw) ? 4'b1111 : 4'b0000;
        wdata = (k == exe_pkg::mem_sb) ? {4{a_rt[id][7:0]}} :
                (k == exe_pkg::mem_sh) ? {2{a_rt[id][15:0]}} : a_rt[id];
        req = (ld || st) && !exc;
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        test_errors++;
        $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic check_result(input logic [31:0] exp_res, input logic [31:0] exp_addr,
            input logic exp_we, input logic [4:0] exp_dest, input exe_pkg::mem_kind_e exp_kind);
        if (out_result !== exp_res) report_value("result", exp_res, out_result);
        if (out_mem_addr !== exp_addr) report_value("mem_addr", exp_addr, out_mem_addr);
        if (out_gr_we !== exp_we) report_value("gr_we", exp_we, out_gr_we);
        if (out_dest !== exp_dest) report_value("dest", exp_dest, out_dest);
        if (out_mem_kind !== exp_kind) report_value("mem_kind", exp_kind, out_mem_kind);
    endtask

    task automatic check_exception(input logic exp_exc, input logic [4:0] exp_code,
            input logic [31:0] exp_badv);
        if (out_except !== exp_exc) report_value("except", exp_exc, out_except);
        if (exp_exc && out_exccode !== exp_code) report_value("exccode", exp_code, out_exccode);
        if (exp_exc && out_badvaddr !== exp_badv)
            report_value("badvaddr", exp_badv, out_badvaddr);
    endtask

    task automatic check_cache_request(input exe_pkg::mem_kind_e kind, input logic [31:0] addr,
            input exe_pkg::cache_size_e size, input logic [3:0] strb, input logic [31:0] wdata);
        logic [31:0] phys;
        logic st;
        phys = addr & 32'h1fff_ffff;
        st = kind inside {exe_pkg::mem_sb, exe_pkg::mem_sh, exe_pkg::mem_sw};
        if (cache_size !== size) report_value("cache_size", size, cache_size);
        if (cache_op !== st) report_value("cache_op", st, cache_op);
        if (cache_wstrb !== strb) report_value("cache_wstrb", strb, cache_wstrb);
        if (st && cache_wdata !== wdata) report_value("cache_wdata", wdata, cache_wdata);
        if ({cache_tag, cache_index, cache_offset} !== phys)
            report_value("cache_addr", phys, {cache_tag, cache_index, cache_offset});
    endtask

    task automatic fail_plain(input string msg);
        errors++;
        test_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    // back-pressure and cache answer, driven after the edge
    always @(posedge clk) begin
        #2;
        pms_allowin <= hold_back ? 1'b0 : ($urandom_range(0, 3) != 0);
        cache_addr_ok <= (wait_cnt == 0);
    end

    // compare process, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        logic [31:0] res, addr, badv, wdata;
        logic exc, req;
        logic [4:0] code;
        logic [3:0] strb;
        exe_pkg::cache_size_e size;
        if (!reset) begin
            if (clear_all) begin
                if (cache_valid || out_valid) fail_plain("stage still active during flush");
                if (exp_q.size() > 0) void'(exp_q.pop_front());
                req_count = 0;
            end else if (exp_q.size() == 0) begin
                if (out_valid || cache_valid) fail_plain("output with no item held");
                if (!allowin) fail_plain("empty stage does not accept a new item");
            end else begin
                exe_model(exp_q[0], res, addr, exc, code, badv, size, strb, wdata, req);
                if (cache_valid && !req)
                    fail_plain("cache request from an item that must not make one");
                if (!req && !out_valid)
                    fail_plain("item without a cache request is not offered downstream");
                if (cache_valid) begin
                    if (cache_addr_ok) begin
                        req_count++;
                        check_cache_request(a_kind[exp_q[0]], addr, size, strb, wdata);
                        wait_cnt = $urandom_range(0, 3);
                    end else if (wait_cnt > 0) begin
                        wait_cnt--;
                    end
                end
                if (out_valid && pms_allowin) begin
                    check_result(res, addr, a_we[exp_q[0]], a_dest[exp_q[0]],
                                 a_kind[exp_q[0]]);
                    check_exception(exc, code, badv);
                    if (req_count != (req ? 1 : 0))
                        fail_plain($sformatf("item %0d made %0d cache requests",
                                             exp_q[0], req_count));
                    void'(exp_q.pop_front());
                    req_count = 0;
                end
            end
            if (ds_valid && allowin && !clear_all) exp_q.push_back(cur_id);
        end
    end

    task automatic random_item(input int id);
        a_op[id] = exe_pkg::alu_op_e'($urandom_range(0, 13));
        a_s1[id] = exe_pkg::src1_sel_e'($urandom_range(0, 2));
        a_s2[id] = exe_pkg::src2_sel_e'($urandom_range(0, 3));
        a_kind[id] = exe_pkg::mem_none;
        a_imm[id] = $urandom();
        a_pc[id] = $urandom();
        a_rs[id] = $urandom();
        a_rt[id] = $urandom();
        a_det[id] = $urandom_range(0, 1);
        a_exc[id] = 1'b0;
        a_we[id] = $urandom_range(0, 1);
        a_code[id] = $urandom_range(0, 31);
        a_dest[id] = $urandom_range(0, 31);
    endtask

    task automatic drive(input int id);
        cur_id = id;
        ds_alu_op = a_op[id];
        ds_src1_sel = a_s1[id];
        ds_src2_sel = a_s2[id];
        ds_imm = a_imm[id];
        ds_pc = a_pc[id];
        ds_rs_value = a_rs[id];
        ds_rt_value = a_rt[id];
        ds_mem_kind = a_kind[id];
        ds_detect_overflow = a_det[id];
        ds_gr_we = a_we[id];
        ds_dest = a_dest[id];
        ds_except = a_exc[id];
        ds_exccode = a_code[id];
        ds_valid = 1'b1;
        @(negedge clk);
        while (!allowin) @(negedge clk);
        @(posedge clk);
        #2 ds_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        test_items = 0;
    endtask

    task automatic finish_test();
        @(negedge clk);
        while (exp_q.size() != 0) @(negedge clk);
        $display("test %s: %0d items, %0d errors", test_name, test_items, test_errors);
        // next stimulus starts just after an edge
        @(posedge clk);
        #2;
    endtask

    task automatic send(input int id);
        drive(id);
        test_items++;
        next_id++;
    endtask

    initial begin
        #((n_items * 20 + 200) * 40);
        $display("watchdog expired with %0d items still pending", exp_q.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hd601b8a0));
        {clear_all, ds_valid, pms_allowin, cache_addr_ok, hold_back} = '0;
        {ds_imm, ds_pc, ds_rs_value, ds_rt_value, ds_dest, ds_exccode} = '0;
        {ds_detect_overflow, ds_gr_we, ds_except} = '0;
        ds_alu_op = exe_pkg::alu_add;
        ds_src1_sel = exe_pkg::src1_rs;
        ds_src2_sel = exe_pkg::src2_rt;
        ds_mem_kind = exe_pkg::mem_none;
        {errors, next_id, wait_cnt, req_count, cur_id} = '0;
        @(negedge reset);
        @(posedge clk);
        #2;

        start_test("alu_ops");
        repeat (300) begin
            random_item(next_id);
            send(next_id);
        end
        finish_test();

        start_test("overflow");
        for (int i = 0; i < 40; i++) begin
            random_item(next_id);
            a_op[next_id] = (i % 2) ? exe_pkg::alu_sub : exe_pkg::alu_add;
            a_s1[next_id] = exe_pkg::src1_rs;
            a_s2[next_id] = exe_pkg::src2_rt;
            a_kind[next_id] = (i % 4 < 2) ? exe_pkg::mem_none : exe_pkg::mem_sw;
            a_det[next_id] = (i % 8 < 4);
            if (i < 8) begin
                a_rs[next_id] = (i % 2) ? 32'h8000_0000 : 32'h7fff_ffff;
                a_rt[next_id] = 32'd1;
            end
            send(next_id);
        end
        finish_test();

        start_test("mem_access");
        for (int i = 0; i < 128; i++) begin
            random_item(next_id);
            a_kind[next_id] = exe_pkg::mem_kind_e'(1 + (i % 8));
            a_rs[next_id][1:0] = 2'((i / 8) % 4) - a_imm[next_id][1:0];
            send(next_id);
        end
        finish_test();

        start_test("random_mix");
        repeat (200) begin
            random_item(next_id);
            a_kind[next_id] = exe_pkg::mem_kind_e'($urandom_range(0, 8));
            a_exc[next_id] = ($urandom_range(0, 7) == 0);
            send(next_id);
        end
        finish_test();

        start_test("decode_except");
        repeat (20) begin
            random_item(next_id);
            a_kind[next_id] = exe_pkg::mem_kind_e'($urandom_range(0, 8));
            a_exc[next_id] = 1'b1;
            send(next_id);
        end
        finish_test();

        start_test("flush");
        repeat (10) begin
            hold_back = 1'b1;
            random_item(next_id);
            a_kind[next_id] = exe_pkg::mem_lw;
            a_rs[next_id][1:0] = 2'd0 - a_imm[next_id][1:0];
            send(next_id);
            clear_all = 1'b1;
            @(posedge clk);
            #2 clear_all = 1'b0;
            hold_back = 1'b0;
            repeat (3) @(posedge clk);
            #2;
        end
        finish_test();

        $display("%0d items, %0d errors", next_id, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: exe_stage.f
exe_pkg.sv
exe_operand_select.sv
exe_alu.sv
exe_mem_request.sv
exe_stage.sv
tb_clock_gen.sv
exe_stage_tb.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - exe_pkg.sv
  - exe_operand_select.sv
  - exe_alu.sv
  - exe_mem_request.sv
  - exe_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - exe_stage_tb.sv
